/* Makefile */
# verilator build and run of the fm output stage testbench

VERILATOR ?= verilator
TOP       ?= fm_acc_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# the log decides the result
run: $(SIM)
	$(SIM) | tee $(LOG)
	@if grep -q "Simulation failed" $(LOG); then \
		echo "result: failing run, see $(LOG)"; exit 1; \
	elif ! grep -q "Simulation passed" $(LOG); then \
		echo "result: run ended without a verdict"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bench/fm_acc_checker.sv */
// strobe and slot order assertions for the fm output stage
`timescale 1ns/1ns

module fm_acc_checker (
    input logic                               clk,
    input logic                               rst_n,
    input logic                               clk_en,
    input logic [fm_alg_pkg::OP_W2-1:0]       slot_op,
    input logic                               ch_valid,
    input logic [fm_alg_pkg::CH_W-1:0]        ch_idx,
    input logic                               frame_done
);

    // operator that follows the presented one, S1 S3 S2 S4 and around
    logic [fm_alg_pkg::OP_W2-1:0] op_after;

    always_comb begin
        case (slot_op)
            fm_alg_pkg::OP_S1: op_after = fm_alg_pkg::OP_S3;
            fm_alg_pkg::OP_S3: op_after = fm_alg_pkg::OP_S2;
            fm_alg_pkg::OP_S2: op_after = fm_alg_pkg::OP_S4;
            default:           op_after = fm_alg_pkg::OP_S1;
        endcase
    end

    a_ch_valid_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        ch_valid |=> !ch_valid) else $error("ch_valid longer than one cycle");

    a_frame_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        frame_done |=> !frame_done) else $error("frame_done longer than one cycle");

    // frame closes only behind channel 6
    a_frame_after_ch5: assert property (@(posedge clk) disable iff (!rst_n)
        frame_done |-> ($past(ch_valid) && $past(ch_idx) == 3'd5))
        else $error("frame_done without a preceding channel 5 result");

    a_slot_step: assert property (@(posedge clk) disable iff (!rst_n)
        clk_en |=> (slot_op == $past(op_after))) else $error("slot_op out of order");

    a_slot_hold: assert property (@(posedge clk) disable iff (!rst_n)
        !clk_en |=> $stable(slot_op)) else $error("slot_op moved without clk_en");

    a_reset_quiet: assert property (@(posedge clk)
        !rst_n |-> (!ch_valid && !frame_done)) else $error("strobe high during reset");

endmodule

bind fm_acc_top fm_acc_checker i_checker (
    .clk        ( clk        ),
    .rst_n      ( rst_n      ),
    .clk_en     ( clk_en     ),
    .slot_op    ( slot_op    ),
    .ch_valid   ( ch_valid   ),
    .ch_idx     ( ch_idx     ),
    .frame_done ( frame_done )
);

/* bench/fm_acc_tb.sv */
// testbench for the fm output stage: lfsr stimulus, reference model, channel and frame checks
`timescale 1ns/1ns

module fm_acc_tb;

    // generous bound for one frame of 24 slots with clk_en at 3 in 4
    localparam int FRAME_TIMEOUT = 200;

    logic                                  clk;
    logic                                  rst_n;
    logic                                  clk_en;
    logic                                  cfg_we;
    logic [fm_alg_pkg::CH_W-1:0]           cfg_ch;
    logic [fm_alg_pkg::ALG_W-1:0]          cfg_alg;
    logic [1:0]                            cfg_rl;
    logic signed [fm_snd_pkg::OP_W-1:0]    op_result;
    logic                                  pcm_en;
    logic [fm_snd_pkg::PCM_W-1:0]          pcm;
    logic [fm_alg_pkg::CH_W-1:0]           slot_ch;
    logic [fm_alg_pkg::OP_W2-1:0]          slot_op;
    logic                                  ch_valid;
    logic [fm_alg_pkg::CH_W-1:0]           ch_idx;
    logic signed [fm_snd_pkg::SUM_W-1:0]   left;
    logic signed [fm_snd_pkg::SUM_W-1:0]   right;
    logic signed [fm_snd_pkg::MIX_W-1:0]   mix_left;
    logic signed [fm_snd_pkg::MIX_W-1:0]   mix_right;
    logic                                  frame_done;

    logic        stim_on;
    logic        hold_en;
    logic        timed_out;
    logic [31:0] lfsr = 32'h90fb606e;
    int          errors;
    int          n_ch;
    int          n_fr;
    int          pcm_hits;
    logic [7:0]  alg_seen;
    logic        seen_ch;

    // model state, slot position and config copy
    logic [2:0]         m_ch;
    logic [1:0]         m_pos;
    logic [2:0]         m_alg [6];
    logic [1:0]         m_rl [6];
    logic [2:0]         m_cur_alg;
    logic [1:0]         m_cur_rl;
    logic               m_primed;
    logic [2:0]         m_sum_ch;
    logic [2:0]         m_sum_alg;
    logic signed [11:0] m_acc_l;
    logic signed [11:0] m_acc_r;

    // expected results, channel sums then frame sums
    logic [2:0]         q_ch [$];
    logic signed [11:0] q_l [$];
    logic signed [11:0] q_r [$];
    logic signed [15:0] q_fl [$];
    logic signed [15:0] q_fr [$];
    logic [2:0]         e_ch;
    logic signed [11:0] e_l;
    logic signed [11:0] e_r;
    logic signed [15:0] f_l;
    logic signed [15:0] f_r;

    fm_acc_top i_fm_acc_top (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .clk_en     ( clk_en     ),
        .cfg_we     ( cfg_we     ),
        .cfg_ch     ( cfg_ch     ),
        .cfg_alg    ( cfg_alg    ),
        .cfg_rl     ( cfg_rl     ),
        .op_result  ( op_result  ),
        .pcm_en     ( pcm_en     ),
        .pcm        ( pcm        ),
        .slot_ch    ( slot_ch    ),
        .slot_op    ( slot_op    ),
        .ch_valid   ( ch_valid   ),
        .ch_idx     ( ch_idx     ),
        .left       ( left       ),
        .right      ( right      ),
        .mix_left   ( mix_left   ),
        .mix_right  ( mix_right  ),
        .frame_done ( frame_done )
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // fibonacci lfsr, taps 32 22 2 1, one step per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    // position in channel to operator, S1 S3 S2 S4 with S1=0 S2=1 S3=2 S4=3
    function automatic logic [1:0] op_at(input logic [1:0] pos);
        case (pos)
            2'd1:    return 2'd2;
            2'd2:    return 2'd1;
            default: return pos;
        endcase
    endfunction

    // operators that reach the output for each algorithm
    function automatic logic is_carrier(input logic [2:0] alg, input logic [1:0] op);
        case (alg)
            3'd4:       return (op == 2'd1) || (op == 2'd3);
            3'd5, 3'd6: return op != 2'd0;
            3'd7:       return 1'b1;
            default:    return op == 2'd3;
        endcase
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("FAIL %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic finish_run();
        $display("channels checked %0d, frames checked %0d, errors %0d", n_ch, n_fr, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    endtask

    // one slot consumed by the model, same edge as the dut
    task automatic consume_slot();
        logic [1:0]         op;
        logic               use_pcm;
        logic               en;
        logic signed [8:0]  val;
        logic signed [11:0] val_ext;
        op      = op_at(m_pos);
        use_pcm = pcm_en && (int'(m_ch) == fm_alg_pkg::PCM_CH);
        en      = use_pcm ? (op == 2'd3) : is_carrier(m_cur_alg, op);
        // offset binary sample, code 256 is zero
        val     = use_pcm ? 9'(int'(pcm) - 256) : op_result;
        val_ext = val;
        if (use_pcm && en) pcm_hits++;
        if (m_pos == 2'd0) begin
            if (m_primed) begin
                q_ch.push_back(m_sum_ch);
                q_l.push_back(m_acc_l);
                q_r.push_back(m_acc_r);
                alg_seen[m_sum_alg] = 1'b1;
            end
            m_primed  = 1'b1;
            m_sum_ch  = m_ch;
            m_sum_alg = m_cur_alg;
            m_acc_l   = (en && m_cur_rl[1]) ? val_ext : 12'sd0;
            m_acc_r   = (en && m_cur_rl[0]) ? val_ext : 12'sd0;
        end else begin
            if (en && m_cur_rl[1]) m_acc_l = m_acc_l + val_ext;
            if (en && m_cur_rl[0]) m_acc_r = m_acc_r + val_ext;
        end
        // settings of the next channel taken at its start
        if (m_pos == 2'd3) begin
            m_ch      = (int'(m_ch) == fm_alg_pkg::NUM_CH - 1) ? 3'd0 : m_ch + 3'd1;
            m_cur_alg = m_alg[m_ch];
            m_cur_rl  = m_rl[m_ch];
        end
        m_pos = m_pos + 2'd1;
    endtask

    // counts frame_done pulses, bounded per frame, skipped once a wait has expired
    task automatic wait_frames(input int n);
        int cycles;
        int seen;
        cycles = 0;
        seen   = 0;
        while (!timed_out && seen < n && cycles < FRAME_TIMEOUT * n) begin
            @(negedge clk);
            cycles++;
            if (frame_done) seen++;
        end
        if (!timed_out && seen < n) begin
            errors++;
            timed_out = 1'b1;
            $display("ERROR: timed out after %0d cycles waiting for frame_done", cycles);
        end
    endtask

    // random stimulus, clk_en high about 3 in 4, config write about 1 in 8
    always @(posedge clk) begin
        if (stim_on) begin
            clk_en    <= hold_en ? 1'b0 : (take_bits(2) != 32'd0);
            op_result <= $signed(9'(take_bits(9)));
            pcm       <= 9'(take_bits(9));
            cfg_we    <= (take_bits(3) == 32'd0);
            cfg_ch    <= 3'(take_bits(3));
            cfg_alg   <= 3'(take_bits(3));
            cfg_rl    <= 2'(take_bits(2));
        end
    end

    // reference model sees the inputs the dut samples on this edge
    always @(posedge clk) begin
        if (rst_n) begin
            if (clk_en) consume_slot();
            // write after the channel load, a same-edge write waits a round
            if (cfg_we && int'(cfg_ch) < fm_alg_pkg::NUM_CH) begin
                m_alg[cfg_ch] = cfg_alg;
                m_rl[cfg_ch]  = cfg_rl;
            end
        end
    end

    // outputs compared mid-cycle
    always @(negedge clk) begin
        if (!rst_n) begin
            check("ch_valid", 32'(ch_valid), 32'd0);
            check("frame_done", 32'(frame_done), 32'd0);
        end else begin
            if (frame_done) begin
                if (q_fl.size() == 0) begin
                    errors++;
                    $display("ERROR: frame_done with no frame completed by the model");
                end else begin
                    check("mix_left", 32'(mix_left), 32'(q_fl.pop_front()));
                    check("mix_right", 32'(mix_right), 32'(q_fr.pop_front()));
                    n_fr++;
                end
            end else if (q_fl.size() != 0) begin
                errors++;
                $display("ERROR: frame_done missing one cycle after channel 5");
                q_fl.delete();
                q_fr.delete();
            end
            if (ch_valid) begin
                if (q_ch.size() == 0) begin
                    errors++;
                    $display("ERROR: ch_valid with no channel finished by the model");
                end else begin
                    e_ch = q_ch.pop_front();
                    e_l  = q_l.pop_front();
                    e_r  = q_r.pop_front();
                    check("ch_idx", 32'(ch_idx), 32'(e_ch));
                    check("left", 32'(left), 32'(e_l));
                    check("right", 32'(right), 32'(e_r));
                    n_ch++;
                    seen_ch = 1'b1;
                    // frame restarts at channel 0
                    if (e_ch == 3'd0) begin
                        f_l = '0;
                        f_r = '0;
                    end
                    f_l = f_l + e_l;
                    f_r = f_r + e_r;
                    if (int'(e_ch) == fm_alg_pkg::NUM_CH - 1) begin
                        q_fl.push_back(f_l);
                        q_fr.push_back(f_r);
                    end
                end
            end else if (q_ch.size() != 0) begin
                errors++;
                $display("ERROR: ch_valid missing after a channel start");
                q_ch.delete();
                q_l.delete();
                q_r.delete();
            end
            check("slot_ch", 32'(slot_ch), 32'(m_ch));
            check("slot_op", 32'(slot_op), 32'(op_at(m_pos)));
        end
        // nothing reported before the first finished channel
        if (!seen_ch) begin
            check("left", 32'(left), 32'd0);
            check("right", 32'(right), 32'd0);
            check("mix_left", 32'(mix_left), 32'd0);
            check("mix_right", 32'(mix_right), 32'd0);
        end
    end

    initial begin
        rst_n     = 1'b0;
        clk_en    = 1'b0;
        cfg_we    = 1'b0;
        cfg_ch    = '0;
        cfg_alg   = '0;
        cfg_rl    = '0;
        op_result = '0;
        pcm_en    = 1'b0;
        pcm       = '0;
        stim_on   = 1'b0;
        hold_en   = 1'b0;
        timed_out = 1'b0;
        errors    = 0;
        n_ch      = 0;
        n_fr      = 0;
        pcm_hits  = 0;
        alg_seen  = '0;
        seen_ch   = 1'b0;
        // model mirrors the reset state
        for (int i = 0; i < 6; i++) begin
            m_alg[i] = 3'd0;
            m_rl[i]  = 2'b11;
        end
        m_ch      = '0;
        m_pos     = '0;
        m_cur_alg = '0;
        m_cur_rl  = 2'b11;
        m_primed  = 1'b0;
        m_sum_ch  = '0;
        m_sum_alg = '0;
        m_acc_l   = '0;
        m_acc_r   = '0;
        f_l       = '0;
        f_r       = '0;
        repeat (3) @(posedge clk);
        rst_n   <= 1'b1;
        stim_on <= 1'b1;
        wait_frames(10);
        // channel 6 as pcm
        @(posedge clk);
        pcm_en <= 1'b1;
        wait_frames(10);
        // clk_en held low, slot must freeze
        @(posedge clk);
        hold_en <= 1'b1;
        repeat (12) @(posedge clk);
        hold_en <= 1'b0;
        wait_frames(4);
        @(posedge clk);
        pcm_en <= 1'b0;
        wait_frames(10);
        if (!timed_out) begin
            if (alg_seen != 8'hff) begin
                errors++;
                $display("ERROR: not every algorithm reached a channel result");
            end
            if (pcm_hits == 0) begin
                errors++;
                $display("ERROR: no pcm sample was summed");
            end
        end
        finish_run();
    end

endmodule

/* design/fm_acc.sv */
// channel accumulator: carrier select, pcm substitution, both side sums and the channel strobe
`timescale 1ns/1ns

module fm_acc (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  clk_en,
    input  logic [fm_alg_pkg::CH_W-1:0]           slot_ch,
    input  logic [fm_alg_pkg::OP_W2-1:0]          slot_op,
    input  logic                                  first_op,
    input  logic [fm_alg_pkg::ALG_W-1:0]          cur_alg,
    input  logic [1:0]                            cur_rl,
    input  logic signed [fm_snd_pkg::OP_W-1:0]    op_result,
    input  logic                                  pcm_en,
    input  logic [fm_snd_pkg::PCM_W-1:0]          pcm,
    output logic                                  ch_valid,
    output logic [fm_alg_pkg::CH_W-1:0]           ch_idx,
    output logic signed [fm_snd_pkg::SUM_W-1:0]   left,
    output logic signed [fm_snd_pkg::SUM_W-1:0]   right
);

    // carriers of the current algorithm
    logic [fm_alg_pkg::NUM_OP-1:0]        alg_mask;
    logic                                 use_pcm;
    logic                                 sum_en;
    logic signed [fm_snd_pkg::OP_W-1:0]   acc_in;
    // latched sum per side
    logic signed [fm_snd_pkg::SUM_W-1:0]  side_snd [fm_snd_pkg::NUM_SIDE];
    // channel whose sum is in progress
    logic [fm_alg_pkg::CH_W-1:0]          sum_ch;
    // set once a channel has been started
    logic                                 primed;

    assign alg_mask = fm_alg_pkg::CARRIER[cur_alg];

    // pcm only ever replaces channel 6
    assign use_pcm = pcm_en && (int'(slot_ch) == fm_alg_pkg::PCM_CH);

    // in pcm mode the sample rides on the S4 slot, other ops ignored
    assign sum_en = use_pcm ? (slot_op == fm_alg_pkg::OP_S4) : alg_mask[slot_op];

    // offset binary to two's complement, flip the msb
    assign acc_in = use_pcm ?
        {~pcm[fm_snd_pkg::PCM_W-1], pcm[fm_snd_pkg::PCM_W-2:0]} : op_result;

    // one accumulator per side, gated by its pan bit
    genvar s;
    generate
        for (s = 0; s < fm_snd_pkg::NUM_SIDE; s++) begin : g_side
            fm_side_acc i_side_acc (
                .clk      ( clk              ),
                .rst_n    ( rst_n            ),
                .clk_en   ( clk_en           ),
                .first_op ( first_op         ),
                .in_val   ( acc_in           ),
                .sum_en   ( sum_en & cur_rl[s] ),
                .snd      ( side_snd[s]      )
            );
        end
    endgenerate

    // pan bit 1 is left, bit 0 right
    assign left  = side_snd[fm_snd_pkg::SIDE_L];
    assign right = side_snd[fm_snd_pkg::SIDE_R];

    // channel-done strobe, lines up with the side latch
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ch_valid <= 1'b0;
            ch_idx   <= '0;
            sum_ch   <= '0;
            primed   <= 1'b0;
        end else begin
            // one clk wide, even if clk_en drops
            ch_valid <= 1'b0;
            if (clk_en && first_op) begin
                sum_ch <= slot_ch;
                primed <= 1'b1;
                // nothing finished before the first channel start
                if (primed) begin
                    ch_valid <= 1'b1;
                    ch_idx   <= sum_ch;
                end
            end
        end
    end

endmodule

/* design/fm_acc_top.sv */
// fm output stage top: slot sequencer, channel accumulator and frame mixer
`timescale 1ns/1ns

module fm_acc_top (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  clk_en,
    input  logic                                  cfg_we,
    input  logic [fm_alg_pkg::CH_W-1:0]           cfg_ch,
    input  logic [fm_alg_pkg::ALG_W-1:0]          cfg_alg,
    input  logic [1:0]                            cfg_rl,
    input  logic signed [fm_snd_pkg::OP_W-1:0]    op_result,
    input  logic                                  pcm_en,
    input  logic [fm_snd_pkg::PCM_W-1:0]          pcm,
    output logic [fm_alg_pkg::CH_W-1:0]           slot_ch,
    output logic [fm_alg_pkg::OP_W2-1:0]          slot_op,
    output logic                                  ch_valid,
    output logic [fm_alg_pkg::CH_W-1:0]           ch_idx,
    output logic signed [fm_snd_pkg::SUM_W-1:0]   left,
    output logic signed [fm_snd_pkg::SUM_W-1:0]   right,
    output logic signed [fm_snd_pkg::MIX_W-1:0]   mix_left,
    output logic signed [fm_snd_pkg::MIX_W-1:0]   mix_right,
    output logic                                  frame_done
);

    // sequencer to accumulator
    logic                          first_op;
    logic [fm_alg_pkg::ALG_W-1:0]  cur_alg;
    logic [1:0]                    cur_rl;

    fm_slot_seq i_slot_seq (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .clk_en   ( clk_en   ),
        .cfg_we   ( cfg_we   ),
        .cfg_ch   ( cfg_ch   ),
        .cfg_alg  ( cfg_alg  ),
        .cfg_rl   ( cfg_rl   ),
        .slot_ch  ( slot_ch  ),
        .slot_op  ( slot_op  ),
        .first_op ( first_op ),
        .cur_alg  ( cur_alg  ),
        .cur_rl   ( cur_rl   )
    );

    // op_result belongs to the slot presented by the sequencer
    fm_acc i_acc (
        .clk       ( clk       ),
        .rst_n     ( rst_n     ),
        .clk_en    ( clk_en    ),
        .slot_ch   ( slot_ch   ),
        .slot_op   ( slot_op   ),
        .first_op  ( first_op  ),
        .cur_alg   ( cur_alg   ),
        .cur_rl    ( cur_rl    ),
        .op_result ( op_result ),
        .pcm_en    ( pcm_en    ),
        .pcm       ( pcm       ),
        .ch_valid  ( ch_valid  ),
        .ch_idx    ( ch_idx    ),
        .left      ( left      ),
        .right     ( right     )
    );

    // drains the channel strobes
    fm_mix i_mix (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .ch_valid   ( ch_valid   ),
        .ch_idx     ( ch_idx     ),
        .left       ( left       ),
        .right      ( right      ),
        .mix_left   ( mix_left   ),
        .mix_right  ( mix_right  ),
        .frame_done ( frame_done )
    );

endmodule

/* design/fm_alg_pkg.sv */
// fm algorithm package: channel and operator counts, slot order, carrier rule per algorithm
package fm_alg_pkg;

    // six channels of four operators each
    localparam int NUM_CH = 6;
    localparam int NUM_OP = 4;

    // index widths
    localparam int CH_W  = 3;
    localparam int OP_W2 = 2;
    localparam int ALG_W = 3;

    // only channel 6 (index 5) can be switched to pcm
    localparam int PCM_CH = 5;

    // operator numbering used on slot_op
    localparam logic [OP_W2-1:0] OP_S1 = 2'd0;
    localparam logic [OP_W2-1:0] OP_S2 = 2'd1;
    localparam logic [OP_W2-1:0] OP_S3 = 2'd2;
    localparam logic [OP_W2-1:0] OP_S4 = 2'd3;

    // pipeline order inside a channel, entry 0 comes first
    // S1, S3, S2, S4
    localparam logic [NUM_OP-1:0][OP_W2-1:0] OP_ORDER = {OP_S4, OP_S2, OP_S3, OP_S1};

    // carrier mask per algorithm, bit n set when operator n is summed
    // algs 0..3 only S4, alg 4 S2+S4, algs 5/6 all but S1, alg 7 all
    localparam logic [2**ALG_W-1:0][NUM_OP-1:0] CARRIER = {
        4'b1111,
        4'b1110,
        4'b1110,
        4'b1010,
        4'b1000,
        4'b1000,
        4'b1000,
        4'b1000
    };

endpackage

/* design/fm_mix.sv */
// frame mixer: adds the six channel sums per side into one stereo frame sample
`timescale 1ns/1ns

module fm_mix (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  ch_valid,
    input  logic [fm_alg_pkg::CH_W-1:0]           ch_idx,
    input  logic signed [fm_snd_pkg::SUM_W-1:0]   left,
    input  logic signed [fm_snd_pkg::SUM_W-1:0]   right,
    output logic signed [fm_snd_pkg::MIX_W-1:0]   mix_left,
    output logic signed [fm_snd_pkg::MIX_W-1:0]   mix_right,
    output logic                                  frame_done
);

    // channel sums widened to the mix width
    logic signed [fm_snd_pkg::MIX_W-1:0] left_ext;
    logic signed [fm_snd_pkg::MIX_W-1:0] right_ext;
    // frame in progress
    logic signed [fm_snd_pkg::MIX_W-1:0] sum_l_q;
    logic signed [fm_snd_pkg::MIX_W-1:0] sum_r_q;
    logic signed [fm_snd_pkg::MIX_W-1:0] nxt_l;
    logic signed [fm_snd_pkg::MIX_W-1:0] nxt_r;
    logic                                frame_start;
    logic                                frame_end;

    assign frame_start = (ch_idx == '0);
    assign frame_end   = (int'(ch_idx) == fm_alg_pkg::NUM_CH - 1);

    assign left_ext = {
        {(fm_snd_pkg::MIX_W - fm_snd_pkg::SUM_W){left[fm_snd_pkg::SUM_W-1]}},
        left
    };
    assign right_ext = {
        {(fm_snd_pkg::MIX_W - fm_snd_pkg::SUM_W){right[fm_snd_pkg::SUM_W-1]}},
        right
    };

    // channel 0 restarts the frame
    assign nxt_l = (frame_start ? '0 : sum_l_q) + left_ext;
    assign nxt_r = (frame_start ? '0 : sum_r_q) + right_ext;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sum_l_q    <= '0;
            sum_r_q    <= '0;
            mix_left   <= '0;
            mix_right  <= '0;
            frame_done <= 1'b0;
        end else begin
            frame_done <= 1'b0;
            if (ch_valid) begin
                sum_l_q <= nxt_l;
                sum_r_q <= nxt_r;
                // last channel closes the frame
                if (frame_end) begin
                    mix_left   <= nxt_l;
                    mix_right  <= nxt_r;
                    frame_done <= 1'b1;
                end
            end
        end
    end

endmodule

/* design/fm_side_acc.sv */
// side accumulator: sums one stereo side of a channel and latches it at the channel boundary
`timescale 1ns/1ns

module fm_side_acc (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  clk_en,
    input  logic                                  first_op,
    input  logic signed [fm_snd_pkg::OP_W-1:0]    in_val,
    input  logic                                  sum_en,
    output logic signed [fm_snd_pkg::SUM_W-1:0]   snd
);

    // running sum of the channel in progress
    logic signed [fm_snd_pkg::SUM_W-1:0] acc_q;
    // input widened to the sum width
    logic signed [fm_snd_pkg::SUM_W-1:0] in_ext;

    // sign extension, no extra headroom needed
    assign in_ext = {
        {(fm_snd_pkg::SUM_W - fm_snd_pkg::OP_W){in_val[fm_snd_pkg::OP_W-1]}},
        in_val
    };

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc_q <= '0;
            snd   <= '0;
        end else if (clk_en) begin
            if (first_op) begin
                // previous channel is done
                snd   <= acc_q;
                // S1 of the new channel may already count
                acc_q <= sum_en ? in_ext : '0;
            end else if (sum_en) begin
                acc_q <= acc_q + in_ext;
            end
        end
    end

endmodule

/* design/fm_slot_seq.sv */
// slot sequencer: walks channels and operators in pipeline order, holds per-channel config
`timescale 1ns/1ns

module fm_slot_seq (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             clk_en,
    input  logic                             cfg_we,
    input  logic [fm_alg_pkg::CH_W-1:0]      cfg_ch,
    input  logic [fm_alg_pkg::ALG_W-1:0]     cfg_alg,
    input  logic [1:0]                       cfg_rl,
    output logic [fm_alg_pkg::CH_W-1:0]      slot_ch,
    output logic [fm_alg_pkg::OP_W2-1:0]     slot_op,
    output logic                             first_op,
    output logic [fm_alg_pkg::ALG_W-1:0]     cur_alg,
    output logic [1:0]                       cur_rl
);

    // channel and position within channel, 24 states together
    logic [fm_alg_pkg::CH_W-1:0]  ch_q;
    logic [fm_alg_pkg::OP_W2-1:0] pos_q;
    logic [fm_alg_pkg::CH_W-1:0]  ch_nxt;
    logic                         last_op;

    // host-written settings per channel
    logic [fm_alg_pkg::ALG_W-1:0] alg_q [fm_alg_pkg::NUM_CH];
    logic [1:0]                   rl_q  [fm_alg_pkg::NUM_CH];

    // S4 is the last slot of a channel
    assign last_op = (int'(pos_q) == fm_alg_pkg::NUM_OP - 1);
    // wrap after channel 6
    assign ch_nxt  = (int'(ch_q) == fm_alg_pkg::NUM_CH - 1) ? '0 : ch_q + 1'b1;

    // presented slot
    assign slot_ch  = ch_q;
    assign slot_op  = fm_alg_pkg::OP_ORDER[pos_q];
    assign first_op = (pos_q == '0);

    // config writes, out of range channels dropped
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < fm_alg_pkg::NUM_CH; i++) begin
                alg_q[i] <= '0;
                rl_q[i]  <= 2'b11;
            end
        end else if (cfg_we && (int'(cfg_ch) < fm_alg_pkg::NUM_CH)) begin
            alg_q[cfg_ch] <= cfg_alg;
            rl_q[cfg_ch]  <= cfg_rl;
        end
    end

    // slot walk, one step per clk_en
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ch_q    <= '0;
            pos_q   <= '0;
            // matches the reset value of channel 0
            cur_alg <= '0;
            cur_rl  <= 2'b11;
        end else if (clk_en) begin
            // four operators per channel, wraps by itself
            pos_q <= pos_q + 1'b1;
            if (last_op) begin
                ch_q    <= ch_nxt;
                // settings frozen for the whole channel
                // a write landing on this same edge waits for the next round
                cur_alg <= alg_q[ch_nxt];
                cur_rl  <= rl_q[ch_nxt];
            end
        end
    end

endmodule

/* design/fm_snd_pkg.sv */
// fm sound package: sample widths from operator result up to the frame mix
package fm_snd_pkg;

    // signed operator result from the operator engine
    localparam int OP_W = 9;

    // pcm sample, offset binary
    localparam int PCM_W = 9;

    // signed per-channel sum
    // four 9-bit carriers at most, so 12 bits never overflow
    localparam int SUM_W = 12;

    // signed frame mix of six channel sums
    localparam int MIX_W = 16;

    // stereo sides, same order as the pan bits
    localparam int NUM_SIDE = 2;
    localparam int SIDE_L   = 1;
    localparam int SIDE_R   = 0;

endpackage

/* verilog.f */
design/fm_alg_pkg.sv
design/fm_snd_pkg.sv
design/fm_slot_seq.sv
design/fm_side_acc.sv
design/fm_acc.sv
design/fm_mix.sv
design/fm_acc_top.sv
bench/fm_acc_checker.sv
bench/fm_acc_tb.sv
